// ==== stream_buffer_params.svh ====
`ifndef STREAM_BUFFER_PARAMS_SVH
`define STREAM_BUFFER_PARAMS_SVH

// Width of one stream byte.
`define SB_BYTE_W 8

// Number of words the FIFO holds.
`define SB_FIFO_DEPTH 8

// Read and write pointer width is log2 of the depth.
`define SB_PTR_W 3

// Occupancy at or above which almost_full is raised.
`define SB_AFULL_LEVEL 6

// Occupancy at or below which almost_empty is raised.
`define SB_AEMPTY_LEVEL 1

`endif

// ==== stream_buffer_pkg.sv ====
`default_nettype none

`include "stream_buffer_params.svh"

package stream_buffer_pkg;

    typedef logic [`SB_BYTE_W-1:0] byte_t;

    // First byte of a pair sits in the upper half.
    typedef logic [2*`SB_BYTE_W-1:0] word_t;

    typedef logic [`SB_PTR_W-1:0] ptr_t;

    // One bit wider than the pointer so a full FIFO can be counted.
    typedef logic [`SB_PTR_W:0] count_t;

    typedef enum logic [1:0] {
        idle  = 2'd0,
        fetch = 2'd1,
        high  = 2'd2,
        low   = 2'd3
    } unpack_state_t;

endpackage

`default_nettype wire

// ==== byte_packer.sv ====
`timescale 1ns/1ns
`default_nettype none

module byte_packer (
    input  wire logic                     clk,
    input  wire logic                     rst_n,
    input  wire logic                     in_valid,
    input  wire stream_buffer_pkg::byte_t in_byte,
    output logic                          wr_en,
    output stream_buffer_pkg::word_t      wr_data
);

    // Low while waiting for the first byte of a pair.
    logic                     half;
    stream_buffer_pkg::byte_t first_byte;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            half <= 1'b0;
        end else if (in_valid) begin
            half <= ~half;
        end
    end

    // Write pulse follows the second byte by one cycle.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_en <= 1'b0;
        end else begin
            wr_en <= in_valid && half;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && !half) begin
            first_byte <= in_byte;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && half) begin
            wr_data <= {first_byte, in_byte};
        end
    end

endmodule

`default_nettype wire

// ==== sync_fifo.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "stream_buffer_params.svh"

module sync_fifo (
    input  wire logic                     clk,
    input  wire logic                     rst_n,
    input  wire logic                     wr_en,
    input  wire stream_buffer_pkg::word_t wr_data,
    input  wire logic                     rd_en,
    output stream_buffer_pkg::word_t      rd_data,
    output logic                          full,
    output logic                          empty,
    output logic                          almost_full,
    output logic                          almost_empty,
    output logic                          overflow,
    output logic                          underflow
);

    localparam stream_buffer_pkg::ptr_t LAST_PTR =
        stream_buffer_pkg::ptr_t'(`SB_FIFO_DEPTH - 1);

    stream_buffer_pkg::word_t  mem [0:`SB_FIFO_DEPTH-1];
    stream_buffer_pkg::ptr_t   wr_ptr;
    stream_buffer_pkg::ptr_t   rd_ptr;
    stream_buffer_pkg::count_t count;

    logic wr_accept;
    logic rd_accept;

    assign wr_accept = wr_en && !full;
    assign rd_accept = rd_en && !empty;

    // Occupancy holds when a write and a read land together.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            count <= '0;
        end else begin
            case ({wr_accept, rd_accept})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Pointers only move, and wrap, on an accepted access.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
        end else if (wr_accept) begin
            wr_ptr <= (wr_ptr == LAST_PTR) ? '0 : wr_ptr + 1'b1;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_ptr <= '0;
        end else if (rd_accept) begin
            rd_ptr <= (rd_ptr == LAST_PTR) ? '0 : rd_ptr + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_accept) begin
            mem[wr_ptr] <= wr_data;
        end
    end

    // Read data is valid the cycle after rd_en.
    always_ff @(posedge clk) begin
        if (rd_accept) begin
            rd_data <= mem[rd_ptr];
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            overflow <= 1'b0;
        end else if (wr_en && full) begin
            overflow <= 1'b1;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            underflow <= 1'b0;
        end else if (rd_en && empty) begin
            underflow <= 1'b1;
        end
    end

    assign full         = (count == stream_buffer_pkg::count_t'(`SB_FIFO_DEPTH));
    assign empty        = (count == '0);
    assign almost_full  = (count >= stream_buffer_pkg::count_t'(`SB_AFULL_LEVEL));
    assign almost_empty = (count <= stream_buffer_pkg::count_t'(`SB_AEMPTY_LEVEL));

endmodule

`default_nettype wire

// ==== byte_unpacker.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "stream_buffer_params.svh"

module byte_unpacker (
    input  wire logic                     clk,
    input  wire logic                     rst_n,
    input  wire logic                     empty,
    input  wire stream_buffer_pkg::word_t rd_data,
    input  wire logic                     out_take,
    output logic                          rd_en,
    output logic                          out_valid,
    output stream_buffer_pkg::byte_t      out_byte
);

    stream_buffer_pkg::unpack_state_t state;
    stream_buffer_pkg::unpack_state_t state_next;
    stream_buffer_pkg::word_t         word;

    always_comb begin
        state_next = state;
        case (state)
            stream_buffer_pkg::idle: begin
                if (!empty) begin
                    state_next = stream_buffer_pkg::fetch;
                end
            end
            stream_buffer_pkg::fetch: begin
                state_next = stream_buffer_pkg::high;
            end
            stream_buffer_pkg::high: begin
                if (out_take) begin
                    state_next = stream_buffer_pkg::low;
                end
            end
            stream_buffer_pkg::low: begin
                if (out_take) begin
                    state_next = stream_buffer_pkg::idle;
                end
            end
            default: begin
                state_next = stream_buffer_pkg::idle;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= stream_buffer_pkg::idle;
        end else begin
            state <= state_next;
        end
    end

    // FIFO read data lands during fetch.
    always_ff @(posedge clk) begin
        if (state == stream_buffer_pkg::fetch) begin
            word <= rd_data;
        end
    end

    assign rd_en     = (state == stream_buffer_pkg::idle) && !empty;
    assign out_valid = (state == stream_buffer_pkg::high) || (state == stream_buffer_pkg::low);

    // High byte first, then low byte.
    assign out_byte = (state == stream_buffer_pkg::low) ? word[`SB_BYTE_W-1:0]
                                                       : word[2*`SB_BYTE_W-1:`SB_BYTE_W];

endmodule

`default_nettype wire

// ==== stream_buffer_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module stream_buffer_top (
    input  wire logic                     clk,
    input  wire logic                     rst_n,
    input  wire logic                     in_valid,
    input  wire stream_buffer_pkg::byte_t in_byte,
    input  wire logic                     out_take,
    output logic                          out_valid,
    output stream_buffer_pkg::byte_t      out_byte,
    output logic                          fifo_full,
    output logic                          fifo_empty,
    output logic                          fifo_almost_full,
    output logic                          fifo_almost_empty,
    output logic                          overflow
);

    logic                     wr_en;
    stream_buffer_pkg::word_t wr_data;
    logic                     rd_en;
    stream_buffer_pkg::word_t rd_data;

    byte_packer byte_packer_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .in_valid (in_valid),
        .in_byte  (in_byte),
        .wr_en    (wr_en),
        .wr_data  (wr_data)
    );

    // The unpacker never reads an empty FIFO, so underflow stays internal.
    sync_fifo sync_fifo_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .wr_en        (wr_en),
        .wr_data      (wr_data),
        .rd_en        (rd_en),
        .rd_data      (rd_data),
        .full         (fifo_full),
        .empty        (fifo_empty),
        .almost_full  (fifo_almost_full),
        .almost_empty (fifo_almost_empty),
        .overflow     (overflow),
        .underflow    ()
    );

    byte_unpacker byte_unpacker_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .empty     (fifo_empty),
        .rd_data   (rd_data),
        .out_take  (out_take),
        .rd_en     (rd_en),
        .out_valid (out_valid),
        .out_byte  (out_byte)
    );

endmodule

`default_nettype wire

// ==== stream_buffer_properties.sv ====
`timescale 1ns/1ns
`default_nettype none

module stream_buffer_properties (
    input wire logic                     clk,
    input wire logic                     rst_n,
    input wire logic                     rd_en,
    input wire logic                     empty,
    input wire logic                     full,
    input wire logic                     out_valid,
    input wire logic                     out_take,
    input wire stream_buffer_pkg::byte_t out_byte
);

    a_no_read_when_empty: assert property (@(posedge clk) disable iff (!rst_n)
        !(rd_en && empty))
        else $error("FIFO read strobe while the FIFO is empty.");

    a_full_and_empty: assert property (@(posedge clk) disable iff (!rst_n)
        !(full && empty))
        else $error("FIFO full and empty at the same time.");

    // A presented byte must hold until the downstream side takes it.
    a_byte_held: assert property (@(posedge clk) disable iff (!rst_n)
        (out_valid && !out_take) |=> $stable(out_byte))
        else $error("Output byte changed while waiting to be taken.");

endmodule

bind sync_fifo stream_buffer_properties fifo_properties_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .rd_en     (rd_en),
    .empty     (empty),
    .full      (full),
    .out_valid (1'b0),
    .out_take  (1'b0),
    .out_byte  (8'h00)
);

bind byte_unpacker stream_buffer_properties unpacker_properties_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .rd_en     (rd_en),
    .empty     (empty),
    .full      (1'b0),
    .out_valid (out_valid),
    .out_take  (out_take),
    .out_byte  (out_byte)
);

`default_nettype wire

// ==== stream_buffer_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "stream_buffer_params.svh"

module stream_buffer_tb;

    typedef enum int {take_always, take_drain, take_random} take_mode_t;

    localparam int NUM_TESTS      = 4;
    localparam int TIMEOUT_CYCLES = 2000;

    // Stimulus table with one test per row.
    string      test_name    [NUM_TESTS] = '{"stream_16", "fill_9_words", "overflow_20",
                                             "random_32"};
    int         byte_count   [NUM_TESTS] = '{16, 18, 20, 32};
    take_mode_t take_mode    [NUM_TESTS] = '{take_always, take_drain, take_drain, take_random};
    int         exp_overflow [NUM_TESTS] = '{0, 0, 1, 0};

    logic                     clk;
    logic                     rst_n;
    logic                     in_valid;
    stream_buffer_pkg::byte_t in_byte;
    logic                     out_take;
    logic                     out_valid;
    stream_buffer_pkg::byte_t out_byte;
    logic                     fifo_full;
    logic                     fifo_empty;
    logic                     fifo_almost_full;
    logic                     fifo_almost_empty;
    logic                     overflow;

    logic [31:0]              rng_state;
    stream_buffer_pkg::byte_t expected_bytes [$];
    int                       sent;
    int                       received;

    stream_buffer_top stream_buffer_top_i (
        .clk               (clk),
        .rst_n             (rst_n),
        .in_valid          (in_valid),
        .in_byte           (in_byte),
        .out_take          (out_take),
        .out_valid         (out_valid),
        .out_byte          (out_byte),
        .fifo_full         (fifo_full),
        .fifo_empty        (fifo_empty),
        .fifo_almost_full  (fifo_almost_full),
        .fifo_almost_empty (fifo_almost_empty),
        .overflow          (overflow)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic stop_on_error(input string msg);
        $display("%s", msg);
        $display("SOME TESTS FAILED");
        $fatal(1, "Simulation stopped at the first error.");
    endtask

    task automatic check_value(input string name, input string what, input int expected,
                               input int actual);
        if (expected != actual) begin
            stop_on_error($sformatf("FAIL %s %s: expected %0d actual %0d",
                                    name, what, expected, actual));
        end
    endtask

    // Inputs change and outputs are sampled 5 ns after the rising edge.
    task automatic next_cycle();
        @(posedge clk);
        #5;
    endtask

    task automatic apply_reset(input string name);
        rst_n    = 1'b0;
        in_valid = 1'b0;
        in_byte  = '0;
        out_take = 1'b0;
        repeat (16) @(posedge clk);
        #5;
        rst_n = 1'b1;
        expected_bytes.delete();
        sent     = 0;
        received = 0;
        check_value(name, "fifo_empty after reset", 1, fifo_empty);
        check_value(name, "fifo_almost_empty after reset", 1, fifo_almost_empty);
        check_value(name, "fifo_full after reset", 0, fifo_full);
        check_value(name, "out_valid after reset", 0, out_valid);
        check_value(name, "overflow after reset", 0, overflow);
    endtask

    task automatic check_fifo_level(input string name, input int count);
        check_value(name, "fifo_full", count == `SB_FIFO_DEPTH, fifo_full);
        check_value(name, "fifo_empty", count == 0, fifo_empty);
        check_value(name, "fifo_almost_full", count >= `SB_AFULL_LEVEL, fifo_almost_full);
        check_value(name, "fifo_almost_empty", count <= `SB_AEMPTY_LEVEL, fifo_almost_empty);
    endtask

    // Bytes past the keep limit belong to dropped words.
    task automatic send_byte(input int keep);
        rng_state = xorshift(rng_state);
        in_byte   = rng_state[7:0];
        in_valid  = 1'b1;
        if (sent < keep) begin
            expected_bytes.push_back(in_byte);
        end
        sent++;
    endtask

    task automatic transfer(input string name, input int n, input int want,
                            input take_mode_t mode, input int accepted_words);
        int cycles;
        cycles = 0;
        while (received < want) begin
            if (cycles == TIMEOUT_CYCLES) begin
                stop_on_error($sformatf("Timeout in %s: only %0d of %0d bytes came out.",
                                        name, received, want));
            end
            if (mode == take_random) begin
                rng_state = xorshift(rng_state);
                out_take  = rng_state[0];
            end else begin
                out_take = 1'b1;
            end
            if (out_valid && out_take) begin
                // One word is held by the unpacker while its bytes go out.
                if (mode == take_drain) begin
                    check_fifo_level(name, accepted_words - received / 2 - 1);
                end
                check_value(name, "out_byte", expected_bytes.pop_front(), out_byte);
                received++;
            end
            if (sent < n && sent - received < 8) begin
                send_byte(n);
            end else begin
                in_valid = 1'b0;
            end
            next_cycle();
            cycles++;
        end
        in_valid = 1'b0;
        out_take = 1'b0;
    endtask

    initial begin
        int af_cycle;
        int full_cycle;
        int accepted_words;
        rng_state = 32'd48;
        for (int t = 0; t < NUM_TESTS; t++) begin
            apply_reset(test_name[t]);
            accepted_words = byte_count[t] / 2;
            if (take_mode[t] == take_drain) begin
                // The FIFO plus the word held in the unpacker.
                if (accepted_words > `SB_FIFO_DEPTH + 1) begin
                    accepted_words = `SB_FIFO_DEPTH + 1;
                end
                af_cycle   = -1;
                full_cycle = -1;
                for (int i = 0; i < byte_count[t] + 6; i++) begin
                    if (i < byte_count[t]) begin
                        send_byte(2 * accepted_words);
                    end else begin
                        in_valid = 1'b0;
                    end
                    if (fifo_almost_full && af_cycle < 0) begin
                        af_cycle = i;
                    end
                    if (fifo_full && full_cycle < 0) begin
                        full_cycle = i;
                    end
                    next_cycle();
                end
                check_value(test_name[t], "almost_full before full", 1,
                            af_cycle >= 0 && af_cycle < full_cycle);
                check_fifo_level(test_name[t], accepted_words - 1);
                check_value(test_name[t], "overflow when filled", exp_overflow[t], overflow);
            end
            transfer(test_name[t], (take_mode[t] == take_drain) ? 0 : byte_count[t],
                     2 * accepted_words, take_mode[t], accepted_words);
            // No byte may follow the last expected one.
            for (int i = 0; i < 4; i++) begin
                check_value(test_name[t], "out_valid after last byte", 0, out_valid);
                next_cycle();
            end
            check_fifo_level(test_name[t], 0);
            check_value(test_name[t], "overflow at end", exp_overflow[t], overflow);
        end
        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== project.f ====
+incdir+.
stream_buffer_pkg.sv
byte_packer.sv
sync_fifo.sv
byte_unpacker.sv
stream_buffer_top.sv
stream_buffer_properties.sv
stream_buffer_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module stream_buffer_tb -f project.f -o stream_buffer_sim

status=0
./obj_dir/stream_buffer_sim > sim.log 2>&1 || status=$?
cat sim.log

if grep -q "SOME TESTS FAILED" sim.log || [ "$status" -ne 0 ]; then
    echo "Simulation failed."
    exit 1
fi
echo "Simulation passed."
